// ==== src/i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// ------------------------------
// SCL timing
// ------------------------------
`define I2C_DIV         200     // clocks per SCL period, multiple of 4

// ------------------------------
// host bus layout
// ------------------------------
`define I2C_SEL_HI      23      // register select field in addr_i
`define I2C_SEL_LO      16
`define I2C_DATA_W      32
`define I2C_REG_W       16      // device register width
`define I2C_CMD_RD_BIT  29      // 1 = read command
`define I2C_CMD_PTR_HI  31      // register pointer field
`define I2C_CMD_PTR_LO  30
`endif

// ==== src/i2c_pkg.sv ====
package i2c_pkg;

    // host register select codes, addr_i[23:16]
    typedef enum logic [7:0] {
        SLAVE_ADDR = 8'd1,
        RDATA      = 8'd2,
        CMD        = 8'd3,
        STATUS     = 8'd4
    } reg_sel_e;

    // protocol FSM
    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        PTR,
        PTR_ACK,
        RESTART,       // repeated start before the read address
        DATA_HI,
        ACK_HI,
        DATA_LO,
        ACK_LO,
        STOP
    } ctrl_state_e;

endpackage

// ==== src/i2c_phase_if.sv ====
`timescale 1ns/1ns

// SCL and its bit-phase strobes
interface i2c_phase_if;

    logic scl;
    logic scl_fall_stb;    // last clock of SCL high
    logic drive_stb;       // middle of SCL low
    logic sample_stb;      // middle of SCL high

    modport source (
        output scl, scl_fall_stb, drive_stb, sample_stb
    );
    modport sink (
        input scl, scl_fall_stb, drive_stb, sample_stb
    );

endinterface

// ==== src/i2c_cmd_if.sv ====
`timescale 1ns/1ns

interface i2c_cmd_if;

    // command side
    logic        start_stb;
    logic        rd;
    logic [6:0]  slave_addr;
    logic [1:0]  pointer;
    logic [15:0] wdata;

    // result side
    logic        busy;
    logic        done_stb;
    logic        nack;
    logic [15:0] rdata;

    modport host (
        output start_stb, rd, slave_addr, pointer, wdata,
        input  busy, done_stb, nack, rdata
    );
    modport engine (
        input  start_stb, rd, slave_addr, pointer, wdata,
        output busy, done_stb, nack, rdata
    );
endinterface

// ==== src/i2c_clk_gen.sv ====
`timescale 1ns/1ns
`include "i2c_config.svh"

module i2c_clk_gen (
    input  logic        clk,
    input  logic        rst,
    i2c_phase_if.source phase
);

    localparam int CNT_W = $clog2(`I2C_DIV);

    localparam logic [CNT_W-1:0] SAMPLE_AT = CNT_W'(`I2C_DIV / 4 - 1);
    localparam logic [CNT_W-1:0] FALL_AT   = CNT_W'(`I2C_DIV / 2 - 1);
    localparam logic [CNT_W-1:0] DRIVE_AT  = CNT_W'(3 * `I2C_DIV / 4 - 1);
    localparam logic [CNT_W-1:0] LAST      = CNT_W'(`I2C_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic             scl_q;

    // free-running divider, one wrap per SCL period
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            scl_q <= 1'b1;       // bus idles with SCL high
        end else begin
            cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
            if (cnt == FALL_AT) begin
                scl_q <= 1'b0;
            end else if (cnt == LAST) begin
                scl_q <= 1'b1;
            end
        end
    end

    assign phase.scl          = scl_q;
    assign phase.scl_fall_stb = (cnt == FALL_AT);
    assign phase.sample_stb   = (cnt == SAMPLE_AT);   // SCL high since count 0
    assign phase.drive_stb    = (cnt == DRIVE_AT);    // SCL low since FALL_AT+1

endmodule

// ==== src/i2c_regs.sv ====
`timescale 1ns/1ns
`include "i2c_config.svh"

module i2c_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  i2c_pkg::reg_sel_e      sel_i,
    input  logic [`I2C_DATA_W-1:0] data_i,
    output logic [`I2C_DATA_W-1:0] data_o,
    i2c_cmd_if.host                cmd
);

    logic [6:0]            slave_addr_q;
    logic                  rd_q;
    logic [1:0]            ptr_q;
    logic [`I2C_REG_W-1:0] wdata_q;
    logic [`I2C_REG_W-1:0] rdata_q;
    logic                  cmd_accept;

    // a CMD write while busy is simply lost
    assign cmd_accept = we_i && (sel_i == i2c_pkg::CMD) && !cmd.busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            slave_addr_q <= '0;
            rdata_q      <= '0;
        end else begin
            if (we_i && sel_i == i2c_pkg::SLAVE_ADDR) begin
                slave_addr_q <= data_i[6:0];
            end
            if (cmd.done_stb) begin
                rdata_q <= cmd.rdata;
            end
        end
    end

    // command word, held for the whole transfer
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            rd_q    <= data_i[`I2C_CMD_RD_BIT];
            ptr_q   <= data_i[`I2C_CMD_PTR_HI:`I2C_CMD_PTR_LO];
            wdata_q <= data_i[`I2C_REG_W-1:0];
        end
    end

    assign cmd.start_stb  = cmd_accept;
    assign cmd.rd         = rd_q;
    assign cmd.pointer    = ptr_q;
    assign cmd.wdata      = wdata_q;
    assign cmd.slave_addr = slave_addr_q;

    // host read mux
    always_comb begin
        data_o = '0;
        case (sel_i)
            i2c_pkg::SLAVE_ADDR: data_o[6:0] = slave_addr_q;
            i2c_pkg::RDATA:      data_o[`I2C_REG_W-1:0] = cmd.done_stb ? cmd.rdata : rdata_q;
            i2c_pkg::STATUS:     data_o[1:0] = {cmd.nack, cmd.busy};
            default:             data_o = '0;
        endcase
    end

endmodule

// ==== src/i2c_ctrl.sv ====
`timescale 1ns/1ns
`include "i2c_config.svh"

module i2c_ctrl (
    input  logic        clk,
    input  logic        rst,
    i2c_phase_if.sink   phase,
    i2c_cmd_if.engine   cmd,
    input  logic        sda_i,
    output logic        sda_oe_o    // 1 pulls SDA low
);

    i2c_pkg::ctrl_state_e  state;
    logic [7:0]            sreg;        // shared tx/rx shift register
    logic [3:0]            bit_cnt;
    logic                  rd_addr;     // second address phase of a read
    logic                  sda_oe;
    logic                  nack_q;
    logic                  done_q;
    logic [`I2C_REG_W-1:0] rdata_q;
    logic                  rx_byte;     // slave drives the data bits
    logic                  rx_ack;      // master drives the ack bit

    assign rx_byte = cmd.rd && (state inside {i2c_pkg::DATA_HI, i2c_pkg::DATA_LO});
    assign rx_ack  = cmd.rd && (state inside {i2c_pkg::ACK_HI, i2c_pkg::ACK_LO});

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= i2c_pkg::IDLE;
            bit_cnt <= '0;
            rd_addr <= 1'b0;
            sda_oe  <= 1'b0;
            nack_q  <= 1'b0;
            done_q  <= 1'b0;
            rdata_q <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                i2c_pkg::IDLE: begin
                    if (cmd.start_stb) begin
                        state   <= i2c_pkg::START;
                        nack_q  <= 1'b0;        // new transfer clears old status
                        rd_addr <= 1'b0;
                    end
                end
                // ------------------------------
                // start and repeated start
                // ------------------------------
                i2c_pkg::START, i2c_pkg::RESTART: begin
                    if (phase.sample_stb) begin
                        sda_oe  <= 1'b1;        // falling SDA with SCL high
                        sreg    <= {cmd.slave_addr, rd_addr};
                        bit_cnt <= '0;
                        state   <= i2c_pkg::ADDR;
                    end
                end
                // ------------------------------
                // byte slots, msb first
                // ------------------------------
                i2c_pkg::ADDR, i2c_pkg::PTR, i2c_pkg::DATA_HI, i2c_pkg::DATA_LO: begin
                    if (phase.sample_stb && rx_byte) begin
                        sreg <= {sreg[6:0], sda_i};
                    end
                    if (phase.drive_stb) begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            // master ACK after the high read byte, else release
                            sda_oe  <= rx_byte && (state == i2c_pkg::DATA_HI);
                            case (state)
                                i2c_pkg::ADDR: state <= i2c_pkg::ADDR_ACK;
                                i2c_pkg::PTR:  state <= i2c_pkg::PTR_ACK;
                                i2c_pkg::DATA_HI: begin
                                    state <= i2c_pkg::ACK_HI;
                                    if (rx_byte) rdata_q[15:8] <= sreg;
                                end
                                default: begin
                                    state <= i2c_pkg::ACK_LO;
                                    if (rx_byte) rdata_q[7:0] <= sreg;
                                end
                            endcase
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sda_oe  <= !rx_byte && !sreg[7];
                            if (!rx_byte) begin
                                sreg <= {sreg[6:0], 1'b0};
                            end
                        end
                    end
                end
                // ------------------------------
                // ack slots, left on SCL fall
                // ------------------------------
                i2c_pkg::ADDR_ACK, i2c_pkg::PTR_ACK, i2c_pkg::ACK_HI, i2c_pkg::ACK_LO: begin
                    if (phase.sample_stb && !rx_ack && sda_i) begin
                        nack_q <= 1'b1;         // slave left SDA high
                    end
                    if (phase.scl_fall_stb) begin
                        if (nack_q || state == i2c_pkg::ACK_LO) begin
                            state <= i2c_pkg::STOP;
                        end else begin
                            case (state)
                                i2c_pkg::ADDR_ACK: begin
                                    if (rd_addr) begin
                                        state <= i2c_pkg::DATA_HI;
                                    end else begin
                                        state <= i2c_pkg::PTR;
                                        sreg  <= {6'b0, cmd.pointer};
                                    end
                                end
                                i2c_pkg::PTR_ACK: begin
                                    if (cmd.rd) begin
                                        state   <= i2c_pkg::RESTART;
                                        rd_addr <= 1'b1;
                                    end else begin
                                        state <= i2c_pkg::DATA_HI;
                                        sreg  <= cmd.wdata[15:8];
                                    end
                                end
                                default: begin  // ACK_HI
                                    state <= i2c_pkg::DATA_LO;
                                    sreg  <= cmd.wdata[7:0];
                                end
                            endcase
                        end
                    end
                end
                i2c_pkg::STOP: begin
                    if (phase.drive_stb) begin
                        sda_oe <= 1'b1;         // SDA low while SCL low
                    end
                    if (phase.sample_stb) begin
                        sda_oe <= 1'b0;         // rising SDA with SCL high
                        state  <= i2c_pkg::IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= i2c_pkg::IDLE;
            endcase
        end
    end

    assign cmd.busy     = (state != i2c_pkg::IDLE);
    assign cmd.done_stb = done_q;
    assign cmd.nack     = nack_q;
    assign cmd.rdata    = rdata_q;
    assign sda_oe_o     = sda_oe;

endmodule

// ==== src/i2c_master.sv ====
`timescale 1ns/1ns
`include "i2c_config.svh"

module i2c_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  logic [`I2C_DATA_W-1:0] addr_i,
    input  logic [`I2C_DATA_W-1:0] data_i,
    output logic [`I2C_DATA_W-1:0] data_o,
    inout  wire                    sda_io,
    output logic                   scl_o
);

    i2c_phase_if phase ();
    i2c_cmd_if   cmd ();

    i2c_pkg::reg_sel_e sel;
    logic              sda_oe;

    assign sel    = i2c_pkg::reg_sel_e'(addr_i[`I2C_SEL_HI:`I2C_SEL_LO]);
    assign sda_io = sda_oe ? 1'b0 : 1'bz;    // open drain, pull-up outside
    assign scl_o  = phase.scl;

    i2c_clk_gen u_clk_gen (
        .clk   (clk),
        .rst   (rst),
        .phase (phase)
    );

    i2c_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .we_i   (we_i),
        .sel_i  (sel),
        .data_i (data_i),
        .data_o (data_o),
        .cmd    (cmd)
    );

    i2c_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .phase    (phase),
        .cmd      (cmd),
        .sda_i    (sda_io),
        .sda_oe_o (sda_oe)
    );

endmodule

// ==== sim/i2c_slave_model.sv ====
`timescale 1ns/1ns

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h48
) (
    input logic scl_i,
    inout wire  sda_io
);

    logic [15:0] regs [0:3];
    logic [7:0]  sreg;          // received byte
    logic [7:0]  tx;            // byte being sent
    logic [1:0]  ptr;
    logic        sda_oe;
    logic        in_ack;        // current SCL period is the ack slot
    logic        reading;
    logic        send_next;     // master acked the last byte
    int          bit_cnt;
    int          stage;         // 0 address, 1 pointer, 2 data, 3 ignore
    int          byte_cnt;

    assign sda_io = sda_oe ? 1'b0 : 1'bz;

    initial begin
        foreach (regs[i]) regs[i] = '0;
        sda_oe  = 1'b0;
        in_ack  = 1'b0;
        reading = 1'b0;
        bit_cnt = 0;
        stage   = 3;
    end

    // START and STOP, SDA moving while SCL is high
    always @(negedge sda_io) begin
        if (scl_i === 1'b1) begin
            stage   = 0;
            bit_cnt = 0;
            in_ack  = 1'b0;
            reading = 1'b0;
        end
    end

    always @(posedge sda_io) begin
        if (scl_i === 1'b1) begin
            stage   = 3;
            reading = 1'b0;
        end
    end

    always @(posedge scl_i) begin
        if (in_ack) begin
            send_next = !sda_io;
        end else if (bit_cnt < 8) begin
            sreg    = {sreg[6:0], sda_io};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl_i) begin
        if (in_ack) begin
            in_ack  = 1'b0;
            bit_cnt = 0;
            sda_oe <= 1'b0;
            if (reading && send_next && byte_cnt < 2) begin
                tx       = (byte_cnt == 0) ? regs[ptr][15:8] : regs[ptr][7:0];
                byte_cnt = byte_cnt + 1;
                sda_oe  <= !tx[7];
            end
        end else if (bit_cnt == 8) begin
            in_ack = 1'b1;
            sda_oe <= 1'b0;         // released for the master ack on reads
            if (!reading) begin
                case (stage)
                    0: begin
                        if (sreg[7:1] == ADDR) begin
                            sda_oe  <= 1'b1;
                            reading  = sreg[0];
                            byte_cnt = 0;
                            stage    = 1;
                        end else begin
                            stage = 3;      // not ours, SDA stays high
                        end
                    end
                    1: begin
                        ptr    = sreg[1:0];
                        stage  = 2;
                        sda_oe <= 1'b1;
                    end
                    2: begin
                        if (byte_cnt == 0) begin
                            regs[ptr][15:8] = sreg;
                        end else begin
                            regs[ptr][7:0] = sreg;
                        end
                        byte_cnt = byte_cnt + 1;
                        sda_oe  <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end else if (reading) begin
            sda_oe <= !tx[7 - bit_cnt];    // msb first
        end
    end

endmodule

// ==== sim/i2c_props.sv ====
`timescale 1ns/1ns

module i2c_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 scl_i,
    input logic                 sda_oe_i,
    input i2c_pkg::ctrl_state_e state_i,
    input logic                 busy_i,
    input logic [15:0]          rdata_i
);

    int fail_cnt = 0;

    // START, RESTART and STOP are the only SDA edges with SCL high
    property sda_moves_with_scl_low;
        @(posedge clk) disable iff (rst)
            (sda_oe_i != $past(sda_oe_i)) &&
            !($past(state_i) inside {i2c_pkg::START, i2c_pkg::RESTART, i2c_pkg::STOP})
            |-> !$past(scl_i);
    endproperty

    assert property (sda_moves_with_scl_low) else begin
        $error("SDA changed while SCL was high during a data or ack bit");
        fail_cnt++;
    end

    assert property (@(posedge clk) rst |=> !busy_i) else begin
        $error("busy was set in the cycle after reset");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (rst) !busy_i |-> $stable(rdata_i)) else begin
        $error("read data changed while the controller was idle");
        fail_cnt++;
    end

endmodule

bind i2c_ctrl i2c_props props0 (
    .clk      (clk),
    .rst      (rst),
    .scl_i    (phase.scl),
    .sda_oe_i (sda_oe),
    .state_i  (state),
    .busy_i   (cmd.busy),
    .rdata_i  (cmd.rdata)
);

// ==== sim/tb_i2c_master.sv ====
`timescale 1ns/1ns
`include "i2c_config.svh"

module tb_i2c_master;

    localparam logic [6:0] MODEL_ADDR = 7'h48;
    localparam int N_XFER = 10 + 10 + 1 + 1;   // transfers on the bus
    localparam int LIMIT  = N_XFER * 45 * `I2C_DIV + 1000;

    logic        clk;
    logic        rst;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    wire  [31:0] rdata;
    wire         sda;
    wire         scl;
    logic [15:0] ref_regs [0:3];   // expected device registers
    integer      seed;
    int          cycles;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests;

    pullup (sda);

    i2c_master dut0 (
        .clk    (clk),
        .rst    (rst),
        .we_i   (we),
        .addr_i (addr),
        .data_i (wdata),
        .data_o (rdata),
        .sda_io (sda),
        .scl_o  (scl)
    );

    i2c_slave_model #(.ADDR(MODEL_ADDR)) slave0 (
        .scl_i  (scl),
        .sda_io (sda)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: transfers did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------
    // host bus
    // ------------------------------
    task automatic bus_write(input i2c_pkg::reg_sel_e sel, input logic [31:0] data);
        @(posedge clk);
        #2;
        we    = 1'b1;
        addr  = 32'(sel) << `I2C_SEL_LO;
        wdata = data;
        @(posedge clk);
        #2;
        we = 1'b0;
    endtask

    task automatic bus_read(input i2c_pkg::reg_sel_e sel, output logic [31:0] data);
        @(posedge clk);
        #2;
        addr = 32'(sel) << `I2C_SEL_LO;
        @(negedge clk);     // data_o settled mid-cycle
        data = rdata;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        do begin
            bus_read(i2c_pkg::STATUS, st);
        end while (st[0]);
    endtask

    // ptr in 31:30, read flag in 29, write data low
    function automatic logic [31:0] cmd_word(input logic rd, input logic [1:0] ptr,
                                             input logic [15:0] data);
        return {ptr, rd, 13'h0, data};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_model(input string what);
        for (int i = 0; i < 4; i++) begin
            check_value(what, slave0.regs[i], ref_regs[i]);
        end
    endtask

    task automatic report_test(input string name);
        tests = tests + 1;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d failed checks", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] got;
        logic [6:0]  sa;
        logic [1:0]  ptr;
        logic [15:0] data;
        clk    = 1'b0;
        rst    = 1'b1;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        seed   = 32'h4dbe;
        cycles = 0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        tests  = 0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        sa = 7'($random(seed));
        bus_write(i2c_pkg::SLAVE_ADDR, 32'(sa));
        bus_read(i2c_pkg::SLAVE_ADDR, got);
        check_value("SLAVE_ADDR", got, 32'(sa));
        bus_read(i2c_pkg::STATUS, got);
        check_value("STATUS after reset", got, 32'h0);
        report_test("register readback");

        bus_write(i2c_pkg::SLAVE_ADDR, 32'(MODEL_ADDR));
        repeat (10) begin
            ptr  = 2'($random(seed));
            data = 16'($random(seed));
            bus_write(i2c_pkg::CMD, cmd_word(1'b0, ptr, data));
            wait_idle();
            ref_regs[ptr] = data;
            bus_read(i2c_pkg::STATUS, got);
            check_value("STATUS after write", got, 32'h0);
            check_value("device register", slave0.regs[ptr], ref_regs[ptr]);
        end
        report_test("random writes");

        foreach (ref_regs[i]) begin
            ref_regs[i]    = 16'($random(seed));
            slave0.regs[i] = ref_regs[i];
        end
        repeat (10) begin
            ptr = 2'($random(seed));
            bus_write(i2c_pkg::CMD, cmd_word(1'b1, ptr, 16'h0));
            wait_idle();
            bus_read(i2c_pkg::RDATA, got);
            check_value("RDATA", got, 32'(ref_regs[ptr]));
        end
        report_test("random reads");

        bus_write(i2c_pkg::SLAVE_ADDR, 32'(MODEL_ADDR ^ 7'h01));
        bus_write(i2c_pkg::CMD, cmd_word(1'b0, 2'($random(seed)), 16'($random(seed))));
        wait_idle();
        bus_read(i2c_pkg::STATUS, got);
        check_value("STATUS after NACK", got, 32'h2);
        check_model("device register after NACK");
        report_test("wrong address");

        // ------------------------------
        // second command lands while busy
        bus_write(i2c_pkg::SLAVE_ADDR, 32'(MODEL_ADDR));
        ptr  = 2'($random(seed));
        data = 16'($random(seed));
        bus_write(i2c_pkg::CMD, cmd_word(1'b0, ptr, data));
        addr = 32'(i2c_pkg::STATUS) << `I2C_SEL_LO;   // first cycle after the write
        @(negedge clk);
        got = rdata;
        check_value("STATUS while busy", got, 32'h1);     // nack already cleared
        bus_write(i2c_pkg::CMD, cmd_word(1'b0, ptr + 2'd1, ~data));
        wait_idle();
        ref_regs[ptr] = data;
        bus_read(i2c_pkg::STATUS, got);
        check_value("STATUS after dropped command", got, 32'h0);
        check_model("device register after dropped command");
        report_test("command while busy");

        $display("%0d tests, %0d checks, %0d failed, %0d assertion failures",
                 tests, checks, errors, dut0.u_ctrl.props0.fail_cnt);
        if (errors == 0 && dut0.u_ctrl.props0.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/i2c_pkg.sv
src/i2c_phase_if.sv
src/i2c_cmd_if.sv
src/i2c_clk_gen.sv
src/i2c_regs.sv
src/i2c_ctrl.sv
src/i2c_master.sv
sim/i2c_slave_model.sv
sim/i2c_props.sv
sim/tb_i2c_master.sv
